// File: design/bp_pkg.sv
// shared predictor types for RV32 with PC[1:0] ignored; tables are sized for 5-bit indices only.
package bp_pkg;

    localparam int XLEN        = 32;
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_W   = 5;
    localparam int BTB_TAG_W   = 25;
    localparam int GHR_W       = 5;

    // every counter starts weakly not taken.
    localparam logic [1:0] PHT_INIT = 2'b01;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        BK_NONE   = 2'd0,
        BK_BRANCH = 2'd1,
        BK_JUMP   = 2'd2
    } br_kind_e;

    typedef enum logic [1:0] {
        OP_OTHER  = 2'd0,
        OP_BRANCH = 2'd1,
        OP_JAL    = 2'd2,
        OP_JALR   = 2'd3
    } ctl_op_e;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
        br_kind_e             kind;
    } btb_entry_t;

    typedef struct packed {
        logic                 en;
        logic [BTB_IDX_W-1:0] idx;
        btb_entry_t           entry;
    } btb_wr_t;

    // the history shift uses the same enable and direction.
    typedef struct packed {
        logic             en;
        logic [GHR_W-1:0] idx;
        logic             taken;
    } pht_upd_t;

    // btb_target is the stored target seen at fetch, used to skip redundant writes.
    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        logic             pred_taken;
        logic [XLEN-1:0]  pred_next;
        logic [GHR_W-1:0] pht_idx;
        logic             btb_hit;
        logic [XLEN-1:0]  btb_target;
    } pred_rec_t;

endpackage

// File: design/btb.sv
// direct-mapped with no same-cycle bypass; a write is seen by reads from the next cycle on.
`timescale 1ns/1ps

module btb (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [bp_pkg::XLEN-1:0] rd_pc_i,
    output logic                   hit_o,
    output bp_pkg::btb_entry_t     entry_o,
    input  bp_pkg::btb_wr_t        wr_i
);

    import bp_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
    logic [XLEN-1:0]        target_q [BTB_ENTRIES];
    br_kind_e               kind_q   [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_TAG_W-1:0] rd_tag;

    // index from PC[6:2], tag from the bits above the index.
    assign rd_idx = rd_pc_i[BTB_IDX_W+1:2];
    assign rd_tag = rd_pc_i[XLEN-1:XLEN-BTB_TAG_W];

    always_comb begin
        entry_o.valid  = valid_q[rd_idx];
        entry_o.tag    = tag_q[rd_idx];
        entry_o.target = target_q[rd_idx];
        entry_o.kind   = kind_q[rd_idx];
    end

    assign hit_o = entry_o.valid && (entry_o.tag == rd_tag);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_i.en) begin
            valid_q[wr_i.idx] <= wr_i.entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            tag_q[wr_i.idx]    <= wr_i.entry.tag;
            target_q[wr_i.idx] <= wr_i.entry.target;
            kind_q[wr_i.idx]   <= wr_i.entry.kind;
        end
    end

    // resolve only installs real control transfers, so a hit always has a kind.
    a_wr_kind: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wr_i.en |-> (wr_i.entry.kind != BK_NONE)
    );

endmodule

// File: design/gshare_pht.sv
// history holds resolved directions only; no speculative update and no clear besides reset.
`timescale 1ns/1ps

module gshare_pht (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic [bp_pkg::XLEN-1:0]  rd_pc_i,
    output logic [bp_pkg::GHR_W-1:0] rd_idx_o,
    output logic                     ctr_taken_o,
    input  bp_pkg::pht_upd_t         upd_i
);

    import bp_pkg::*;

    localparam int PHT_N = 1 << GHR_W;

    logic [GHR_W-1:0] ghr_q;
    logic [1:0]       pht_q [PHT_N];
    logic [1:0]       ctr_cur;
    logic [1:0]       ctr_nxt;

    // gshare hash of the word address and the global history.
    assign rd_idx_o    = rd_pc_i[GHR_W+1:2] ^ ghr_q;
    assign ctr_taken_o = pht_q[rd_idx_o][1];

    assign ctr_cur = pht_q[upd_i.idx];

    always_comb begin
        ctr_nxt = ctr_cur;
        if (upd_i.taken) begin
            if (ctr_cur != 2'b11) begin
                ctr_nxt = ctr_cur + 2'b01;
            end
        end else begin
            if (ctr_cur != 2'b00) begin
                ctr_nxt = ctr_cur - 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_N; i++) begin
                pht_q[i] <= PHT_INIT;
            end
        end else if (upd_i.en) begin
            pht_q[upd_i.idx] <= ctr_nxt;
        end
    end

    // newest direction enters at bit 0.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (upd_i.en) begin
            ghr_q <= {ghr_q[GHR_W-2:0], upd_i.taken};
        end
    end

    // a saturated counter pushed further in its own direction keeps its value.
    a_ctr_sat: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (upd_i.en && (ctr_cur == {2{upd_i.taken}}))
            |=> (pht_q[$past(upd_i.idx)] == $past(ctr_cur))
    );

endmodule

// File: design/fetch_predict_stage.sv
// prediction is combinational from the table reads; the decode record is dropped on redirect.
`timescale 1ns/1ps

module fetch_predict_stage (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     fetch_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  fetch_pc_i,
    input  logic                     btb_hit_i,
    input  bp_pkg::btb_entry_t       btb_entry_i,
    input  logic                     ctr_taken_i,
    input  logic [bp_pkg::GHR_W-1:0] pht_idx_i,
    input  logic                     redirect_i,
    output logic                     pred_taken_o,
    output logic [bp_pkg::XLEN-1:0]  pred_next_pc_o,
    output bp_pkg::pred_rec_t        dec_rec_o
);

    import bp_pkg::*;

    logic      is_jump;
    logic      is_branch;
    pred_rec_t rec_d;

    assign is_jump   = btb_hit_i && (btb_entry_i.kind == BK_JUMP);
    assign is_branch = btb_hit_i && (btb_entry_i.kind == BK_BRANCH);

    // jumps are always taken, branches follow the counter msb.
    assign pred_taken_o   = is_jump || (is_branch && ctr_taken_i);
    assign pred_next_pc_o = pred_taken_o ? btb_entry_i.target : fetch_pc_i + XLEN'(4);

    always_comb begin
        rec_d.valid      = fetch_valid_i && !redirect_i;
        rec_d.pc         = fetch_pc_i;
        rec_d.pred_taken = pred_taken_o;
        rec_d.pred_next  = pred_next_pc_o;
        rec_d.pht_idx    = pht_idx_i;
        rec_d.btb_hit    = btb_hit_i;
        rec_d.btb_target = btb_entry_i.target;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_rec_o.valid <= 1'b0;
        end else begin
            dec_rec_o.valid <= rec_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_rec_o.pc         <= rec_d.pc;
        dec_rec_o.pred_taken <= rec_d.pred_taken;
        dec_rec_o.pred_next  <= rec_d.pred_next;
        dec_rec_o.pht_idx    <= rec_d.pht_idx;
        dec_rec_o.btb_hit    <= rec_d.btb_hit;
        dec_rec_o.btb_target <= rec_d.btb_target;
    end

endmodule

// File: design/resolve_stage.sv
// execute inputs must belong to the record in the execute slot; the host never stalls.
`timescale 1ns/1ps

module resolve_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  bp_pkg::pred_rec_t       dec_rec_i,
    input  logic [6:0]              ex_opcode_i,
    input  logic                    ex_taken_i,
    input  logic [bp_pkg::XLEN-1:0] ex_target_i,
    output logic                    redirect_o,
    output logic [bp_pkg::XLEN-1:0] redirect_pc_o,
    output bp_pkg::btb_wr_t         btb_wr_o,
    output bp_pkg::pht_upd_t        pht_upd_o
);

    import bp_pkg::*;

    pred_rec_t       ex_rec_q;
    ctl_op_e         ex_op;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] actual_next;
    logic            is_ctl;
    logic            tgt_stale;

    always_comb begin
        case (ex_opcode_i)
            OPC_BRANCH: ex_op = OP_BRANCH;
            OPC_JAL:    ex_op = OP_JAL;
            OPC_JALR:   ex_op = OP_JALR;
            default:    ex_op = OP_OTHER;
        endcase
    end

    assign pc_plus4 = ex_rec_q.pc + XLEN'(4);

    always_comb begin
        case (ex_op)
            OP_JAL, OP_JALR: actual_next = ex_target_i;
            OP_BRANCH:       actual_next = ex_taken_i ? ex_target_i : pc_plus4;
            default:         actual_next = pc_plus4;
        endcase
    end

    assign redirect_o    = ex_rec_q.valid && (actual_next != ex_rec_q.pred_next);
    assign redirect_pc_o = actual_next;

    // a redirect squashes whatever is sitting in decode.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_rec_q.valid <= 1'b0;
        end else begin
            ex_rec_q.valid <= dec_rec_i.valid && !redirect_o;
        end
    end

    always_ff @(posedge clk) begin
        ex_rec_q.pc         <= dec_rec_i.pc;
        ex_rec_q.pred_taken <= dec_rec_i.pred_taken;
        ex_rec_q.pred_next  <= dec_rec_i.pred_next;
        ex_rec_q.pht_idx    <= dec_rec_i.pht_idx;
        ex_rec_q.btb_hit    <= dec_rec_i.btb_hit;
        ex_rec_q.btb_target <= dec_rec_i.btb_target;
    end

    assign is_ctl    = (ex_op != OP_OTHER);
    assign tgt_stale = !ex_rec_q.btb_hit || (ex_rec_q.btb_target != ex_target_i);

    always_comb begin
        btb_wr_o.en           = ex_rec_q.valid && is_ctl && tgt_stale;
        btb_wr_o.idx          = ex_rec_q.pc[BTB_IDX_W+1:2];
        btb_wr_o.entry.valid  = 1'b1;
        btb_wr_o.entry.tag    = ex_rec_q.pc[XLEN-1:XLEN-BTB_TAG_W];
        btb_wr_o.entry.target = ex_target_i;
        btb_wr_o.entry.kind   = (ex_op == OP_BRANCH) ? BK_BRANCH : BK_JUMP;
    end

    // counters train at the index that fetch used, not the current hash.
    always_comb begin
        pht_upd_o.en    = ex_rec_q.valid && (ex_op == OP_BRANCH);
        pht_upd_o.idx   = ex_rec_q.pht_idx;
        pht_upd_o.taken = ex_taken_i;
    end

    // a redirect flushes the next execute record, so two never come back to back.
    a_redirect_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> (ex_rec_q.valid && !$past(redirect_o))
    );

endmodule

// File: design/branch_predictor_top.sv
// prediction in the fetch cycle, redirect exactly two cycles after fetch; no stall input.
`timescale 1ns/1ps

module branch_predictor_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    fetch_valid_i,
    input  logic [bp_pkg::XLEN-1:0] fetch_pc_i,
    input  logic [6:0]              ex_opcode_i,
    input  logic                    ex_taken_i,
    input  logic [bp_pkg::XLEN-1:0] ex_target_i,
    output logic                    pred_taken_o,
    output logic [bp_pkg::XLEN-1:0] pred_next_pc_o,
    output logic                    redirect_o,
    output logic [bp_pkg::XLEN-1:0] redirect_pc_o
);

    import bp_pkg::*;

    logic             btb_hit;
    btb_entry_t       btb_entry;
    btb_wr_t          btb_wr;
    logic [GHR_W-1:0] pht_idx;
    logic             ctr_taken;
    pht_upd_t         pht_upd;
    pred_rec_t        dec_rec;

    btb btb_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rd_pc_i (fetch_pc_i),
        .hit_o   (btb_hit),
        .entry_o (btb_entry),
        .wr_i    (btb_wr)
    );

    gshare_pht gshare_pht_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rd_pc_i     (fetch_pc_i),
        .rd_idx_o    (pht_idx),
        .ctr_taken_o (ctr_taken),
        .upd_i       (pht_upd)
    );

    fetch_predict_stage fetch_predict_stage_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pc_i     (fetch_pc_i),
        .btb_hit_i      (btb_hit),
        .btb_entry_i    (btb_entry),
        .ctr_taken_i    (ctr_taken),
        .pht_idx_i      (pht_idx),
        .redirect_i     (redirect_o),
        .pred_taken_o   (pred_taken_o),
        .pred_next_pc_o (pred_next_pc_o),
        .dec_rec_o      (dec_rec)
    );

    resolve_stage resolve_stage_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dec_rec_i     (dec_rec),
        .ex_opcode_i   (ex_opcode_i),
        .ex_taken_i    (ex_taken_i),
        .ex_target_i   (ex_target_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .btb_wr_o      (btb_wr),
        .pht_upd_o     (pht_upd)
    );

endmodule

// File: verif/tb_clock_gen.sv
// free-running clock; reset is held low for the first RESET_CYCLES rising edges.
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge so the first active cycle is a whole one.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: verif/tb_branch_predictor.sv
// directed tests with a cycle model; execute inputs always follow their fetch by two cycles.
`timescale 1ns/1ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int PERIOD_NS = 40;
    localparam logic [6:0] OPC_NOP = 7'h13;

    localparam logic [31:0] JMP_PC  = 32'h0000_0104;
    localparam logic [31:0] JMP_TGT = 32'h0000_0400;
    localparam logic [31:0] BR_PC   = 32'h0000_0210;
    localparam logic [31:0] BR_TGT  = 32'h0000_0260;
    localparam logic [31:0] FL_PC   = 32'h0000_2020;
    localparam logic [31:0] FL_TGT  = 32'h0000_3000;

    // cycle budget of each test, used by the watchdog.
    localparam int RESET_CYC  = 4;
    localparam int T_RESET    = 6;
    localparam int T_JUMP     = 10;
    localparam int T_BRANCH   = 76;
    localparam int T_ALIAS    = 6;
    localparam int T_FLUSH    = 10;
    localparam int T_RANDOM   = 202;
    localparam int MARGIN     = 100;
    localparam int MAX_CYCLES = RESET_CYC + T_RESET + T_JUMP + T_BRANCH + T_ALIAS
                              + T_FLUSH + T_RANDOM + MARGIN;

    typedef struct packed {
        logic [6:0]  opc;
        logic        taken;
        logic [31:0] target;
    } ex_info_t;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic [6:0]  ex_opcode;
    logic        ex_taken;
    logic [31:0] ex_target;
    logic        pred_taken;
    logic [31:0] pred_next_pc;
    logic        redirect;
    logic [31:0] redirect_pc;

    // reference model state.
    logic        m_valid  [32];
    logic [24:0] m_tag    [32];
    logic [31:0] m_target [32];
    br_kind_e    m_kind   [32];
    logic [1:0]  m_pht    [32];
    logic [4:0]  m_ghr;
    logic        d_valid, e_valid;
    logic [31:0] d_pc, e_pc, d_next, e_next, d_tgt, e_tgt;
    logic [4:0]  d_idx, e_idx;
    logic        d_hit, e_hit;
    ex_info_t    ex_q [$];

    logic        obs_pred_taken;
    logic [31:0] obs_pred_next;
    logic        obs_redirect;
    logic [31:0] obs_redirect_pc;
    int          err_count;
    int          check_count;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(3)) tb_clock_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    branch_predictor_top branch_predictor_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_pc_i     (fetch_pc),
        .ex_opcode_i    (ex_opcode),
        .ex_taken_i     (ex_taken),
        .ex_target_i    (ex_target),
        .pred_taken_o   (pred_taken),
        .pred_next_pc_o (pred_next_pc),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-14s %s (%0d errors)", name,
                 (err_count == errs_before) ? "ok" : "failed", err_count - errs_before);
    endtask

    function automatic logic entry_hit(input logic [31:0] pc);
        return m_valid[pc[6:2]] && (m_tag[pc[6:2]] == pc[31:7]);
    endfunction

    task automatic clear_model();
        for (int i = 0; i < 32; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_kind[i]   = BK_NONE;
            m_pht[i]    = 2'b01;
        end
        m_ghr   = '0;
        d_valid = 1'b0;
        e_valid = 1'b0;
        {d_pc, e_pc, d_next, e_next, d_tgt, e_tgt} = '0;
        {d_idx, e_idx, d_hit, e_hit} = '0;
        ex_q.delete();
        ex_q.push_back(ex_info_t'({OPC_NOP, 1'b0, 32'h0}));
        ex_q.push_back(ex_info_t'({OPC_NOP, 1'b0, 32'h0}));
    endtask

    // each call drives at the falling edge, checks a quarter period later and steps the model.
    task automatic run_cycle(input string name, input logic fv, input logic [31:0] pc,
                             input logic [6:0] opc, input logic tk, input logic [31:0] tgt);
        ex_info_t    info;
        logic [4:0]  bidx;
        logic [4:0]  pidx;
        logic        hit;
        logic [31:0] hit_tgt;
        logic        ptaken;
        logic [31:0] pnext;
        logic        is_br;
        logic        is_jmp;
        logic [31:0] actual;
        logic        redir;
        ex_q.push_back(ex_info_t'({opc, tk, tgt}));
        info        = ex_q.pop_front();
        fetch_valid = fv;
        fetch_pc    = pc;
        ex_opcode   = info.opc;
        ex_taken    = info.taken;
        ex_target   = info.target;
        bidx    = pc[6:2];
        pidx    = pc[6:2] ^ m_ghr;
        hit     = entry_hit(pc);
        hit_tgt = m_target[bidx];
        ptaken  = hit && ((m_kind[bidx] == BK_JUMP)
                  || ((m_kind[bidx] == BK_BRANCH) && m_pht[pidx][1]));
        pnext   = ptaken ? hit_tgt : pc + 32'd4;
        is_br   = (info.opc == OPC_BRANCH);
        is_jmp  = (info.opc == OPC_JAL) || (info.opc == OPC_JALR);
        if (is_jmp || (is_br && info.taken)) begin
            actual = info.target;
        end else begin
            actual = e_pc + 32'd4;
        end
        redir = e_valid && (actual != e_next);
        #(PERIOD_NS / 4);
        obs_pred_taken  = pred_taken;
        obs_pred_next   = pred_next_pc;
        obs_redirect    = redirect;
        obs_redirect_pc = redirect_pc;
        check_value(name, 32'(ptaken), 32'(obs_pred_taken));
        check_value(name, pnext, obs_pred_next);
        check_value(name, 32'(redir), 32'(obs_redirect));
        if (redir) begin
            check_value(name, actual, obs_redirect_pc);
        end
        if (e_valid && (is_br || is_jmp) && (!e_hit || (e_tgt != info.target))) begin
            m_valid[e_pc[6:2]]  = 1'b1;
            m_tag[e_pc[6:2]]    = e_pc[31:7];
            m_target[e_pc[6:2]] = info.target;
            m_kind[e_pc[6:2]]   = is_br ? BK_BRANCH : BK_JUMP;
        end
        if (e_valid && is_br) begin
            if (info.taken && (m_pht[e_idx] != 2'b11)) begin
                m_pht[e_idx] = m_pht[e_idx] + 2'b01;
            end else if (!info.taken && (m_pht[e_idx] != 2'b00)) begin
                m_pht[e_idx] = m_pht[e_idx] - 2'b01;
            end
            m_ghr = {m_ghr[3:0], info.taken};
        end
        // a redirect drops the decode record and the fetch of this cycle.
        e_valid = d_valid && !redir;
        {e_pc, e_next, e_idx, e_hit, e_tgt} = {d_pc, d_next, d_idx, d_hit, d_tgt};
        d_valid = fv && !redir;
        {d_pc, d_next, d_idx, d_hit, d_tgt} = {pc, pnext, pidx, hit, hit_tgt};
        @(negedge clk);
    endtask

    task automatic idle_cycles(input string name, input int n);
        repeat (n) run_cycle(name, 1'b0, 32'h0, OPC_NOP, 1'b0, 32'h0);
    endtask

    task automatic reset_predict();
        int          errs;
        logic [31:0] pc;
        errs = err_count;
        for (int i = 0; i < 6; i++) begin
            pc = 32'h0000_0040 + 32'(i) * 32'h24;
            run_cycle("reset_predict", 1'b1, pc, OPC_NOP, 1'b0, 32'h0);
            check_value("reset_predict", 32'd0, 32'(obs_pred_taken));
            check_value("reset_predict", pc + 32'd4, obs_pred_next);
        end
        report_test("reset_predict", errs);
    endtask

    task automatic jump_learn();
        int errs;
        errs = err_count;
        run_cycle("jump_learn", 1'b1, JMP_PC, OPC_JAL, 1'b1, JMP_TGT);
        run_cycle("jump_learn", 1'b1, JMP_PC + 32'd4, OPC_JAL, 1'b1, 32'h0000_0800);
        run_cycle("jump_learn", 1'b1, JMP_PC + 32'd8, OPC_JAL, 1'b1, 32'h0000_0900);
        check_value("jump_learn", 32'd1, 32'(obs_redirect));
        check_value("jump_learn", JMP_TGT, obs_redirect_pc);
        // both wrong-path records must stay silent.
        idle_cycles("jump_learn", 1);
        check_value("jump_learn", 32'd0, 32'(obs_redirect));
        idle_cycles("jump_learn", 1);
        check_value("jump_learn", 32'd0, 32'(obs_redirect));
        run_cycle("jump_learn", 1'b1, JMP_PC, OPC_JAL, 1'b1, JMP_TGT);
        check_value("jump_learn", 32'd1, 32'(obs_pred_taken));
        check_value("jump_learn", JMP_TGT, obs_pred_next);
        idle_cycles("jump_learn", 2);
        report_test("jump_learn", errs);
    endtask

    task automatic branch_train();
        int   errs;
        logic exp_taken;
        logic seen_taken;
        logic seen_not_taken;
        errs           = err_count;
        seen_taken     = 1'b0;
        seen_not_taken = 1'b0;
        for (int i = 0; i < 12; i++) begin
            exp_taken = entry_hit(BR_PC) && (m_pht[BR_PC[6:2] ^ m_ghr] >= 2'b10);
            run_cycle("branch_train", 1'b1, BR_PC, OPC_BRANCH, 1'b1, BR_TGT);
            check_value("branch_train", 32'(exp_taken), 32'(obs_pred_taken));
            seen_taken = seen_taken | obs_pred_taken;
            idle_cycles("branch_train", 2);
        end
        check_value("branch_train", 32'd1, 32'(seen_taken));
        for (int i = 0; i < 12; i++) begin
            exp_taken = entry_hit(BR_PC) && (m_pht[BR_PC[6:2] ^ m_ghr] >= 2'b10);
            run_cycle("branch_train", 1'b1, BR_PC, OPC_BRANCH, 1'b0, BR_TGT);
            check_value("branch_train", 32'(exp_taken), 32'(obs_pred_taken));
            seen_not_taken = seen_not_taken | !obs_pred_taken;
            idle_cycles("branch_train", 2);
        end
        check_value("branch_train", 32'd1, 32'(seen_not_taken));
        report_test("branch_train", errs);
    endtask

    task automatic alias_miss();
        int errs;
        errs = err_count;
        run_cycle("alias", 1'b1, JMP_PC, OPC_JAL, 1'b1, JMP_TGT);
        check_value("alias", 32'd1, 32'(obs_pred_taken));
        run_cycle("alias", 1'b1, JMP_PC + 32'h80, OPC_NOP, 1'b0, 32'h0);
        check_value("alias", 32'd0, 32'(obs_pred_taken));
        check_value("alias", JMP_PC + 32'h84, obs_pred_next);
        idle_cycles("alias", 2);
        report_test("alias", errs);
    endtask

    task automatic flush_drop();
        int errs;
        errs = err_count;
        run_cycle("flush", 1'b1, FL_PC, OPC_JALR, 1'b1, FL_TGT);
        run_cycle("flush", 1'b1, FL_PC + 32'd4, OPC_JAL, 1'b1, 32'h0000_3300);
        run_cycle("flush", 1'b1, FL_PC + 32'd8, OPC_JAL, 1'b1, 32'h0000_3400);
        check_value("flush", 32'd1, 32'(obs_redirect));
        check_value("flush", FL_TGT, obs_redirect_pc);
        idle_cycles("flush", 1);
        check_value("flush", 32'd0, 32'(obs_redirect));
        idle_cycles("flush", 1);
        check_value("flush", 32'd0, 32'(obs_redirect));
        // neither dropped record may have installed a buffer entry.
        run_cycle("flush", 1'b1, FL_PC + 32'd4, OPC_NOP, 1'b0, 32'h0);
        check_value("flush", 32'd0, 32'(obs_pred_taken));
        check_value("flush", FL_PC + 32'd8, obs_pred_next);
        run_cycle("flush", 1'b1, FL_PC + 32'd8, OPC_NOP, 1'b0, 32'h0);
        check_value("flush", 32'd0, 32'(obs_pred_taken));
        check_value("flush", FL_PC + 32'd12, obs_pred_next);
        idle_cycles("flush", 2);
        report_test("flush", errs);
    endtask

    task automatic random_stream();
        int          errs;
        logic [31:0] pc;
        logic [31:0] tgt;
        logic [6:0]  opc;
        logic        fv;
        logic        tk;
        errs = err_count;
        for (int i = 0; i < 200; i++) begin
            pc = 32'h0000_4000 + 32'($urandom_range(7)) * 32'd4;
            if ($urandom_range(3) == 0) begin
                pc = pc + 32'h80;
            end
            case ($urandom_range(3))
                0:       opc = OPC_BRANCH;
                1:       opc = OPC_JAL;
                2:       opc = OPC_JALR;
                default: opc = 7'h33;
            endcase
            tk  = 1'($urandom_range(1));
            tgt = 32'h0000_5000 + 32'($urandom_range(3)) * 32'h10;
            fv  = ($urandom_range(7) != 0);
            run_cycle("random_stream", fv, pc, opc, tk, tgt);
        end
        idle_cycles("random_stream", 2);
        report_test("random_stream", errs);
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(96));
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        ex_opcode   = OPC_NOP;
        ex_taken    = 1'b0;
        ex_target   = '0;
        err_count   = 0;
        check_count = 0;
        clear_model();
        @(posedge rst_n);
        reset_predict();
        jump_learn();
        branch_train();
        alias_miss();
        flush_drop();
        random_stream();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: project.f
design/bp_pkg.sv
design/btb.sv
design/gshare_pht.sv
design/fetch_predict_stage.sv
design/resolve_stage.sv
design/branch_predictor_top.sv
verif/tb_clock_gen.sv
verif/tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_branch_predictor \
    -f project.f -o tb_sim &&
    ./obj_dir/tb_sim | tee sim.log

grep -qsx "Done: no errors" sim.log && echo "simulation passed" && exit 0 ||
    { echo "simulation failed"; exit 1; }
